// ==== fetch_unit.f ====
+incdir+include
hw/fetch_types_pkg.sv
hw/fetch_ctrl_pkg.sv
hw/fetch_stage.sv
hw/fetch_buffer.sv
hw/instr_predecode.sv
hw/fetch_unit.sv
verification/fetch_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the fetch unit testbench.

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= fetch_unit.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= sim passed

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/fetch_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_unit_tb;

  import fetch_types_pkg::*;
  import fetch_ctrl_pkg::*;

  localparam int run_outputs = 60;
  localparam int tail_outputs = 16;
  localparam int redirect_count = 3;
  localparam int total_outputs = 2 * run_outputs + redirect_count * (3 + tail_outputs);
  localparam int cycles_per_output = 50; // Generous for random stalls and flushes.
  localparam int watchdog_cycles = (total_outputs + 8 * redirect_count) * cycles_per_output + 200;
  localparam int watchdog_ns = watchdog_cycles * 8;

  logic   clock;
  logic   reset;
  logic   imem_valid;
  addr_t  imem_addr;
  logic   imem_ready;
  instr_t imem_rdata;
  logic   trap;
  addr_t  trap_vector;
  logic   mret;
  addr_t  return_pc;
  logic   branch_redirect;
  addr_t  branch_target;
  logic   out_valid;
  addr_t  out_pc;
  instr_t out_instr;
  logic   out_compressed;
  logic   out_jump;
  logic   out_ready;

  logic [31:0] seed;
  logic        random_mode;
  int          phase;
  addr_t       exp_pc;
  logic        target_pending;
  addr_t       pending_target;
  logic        first_req_pending;
  addr_t       first_stream[$];
  int          stream_index;
  int          transfers;
  int          jumps_seen;
  int          compressed_seen;
  int          mismatches;
  int          failures;

  fetch_unit UUT (
    .clock           (clock),
    .reset           (reset),
    .imem_valid      (imem_valid),
    .imem_addr       (imem_addr),
    .imem_ready      (imem_ready),
    .imem_rdata      (imem_rdata),
    .trap            (trap),
    .trap_vector     (trap_vector),
    .mret            (mret),
    .return_pc       (return_pc),
    .branch_redirect (branch_redirect),
    .branch_target   (branch_target),
    .out_valid       (out_valid),
    .out_pc          (out_pc),
    .out_instr       (out_instr),
    .out_compressed  (out_compressed),
    .out_jump        (out_jump),
    .out_ready       (out_ready)
  );

  always #4 clock = ~clock;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Program image, one hashed halfword per address.
  function automatic logic [15:0] image_half(input addr_t addr);
    logic [31:0] h;
    h = (addr >> 1) ^ (addr >> 17); // High bits folded into the low half.
    h = h * 32'h9E37_79B1;
    h = h ^ (h >> 13);
    case (h[2:0])
      3'd0, 3'd1, 3'd2: return {h[18:5], 2'b10}; // Plain compressed.
      3'd3, 3'd4, 3'd5: return {h[17:9], 7'b0010011}; // Low half of an OP-IMM.
      3'd6: return {h[12:9], 5'd1, 7'b1101111}; // Low half of a JAL.
      default: return {3'b101, 1'b0, h[11], 3'b000, h[7], h[6], h[5], h[4], 1'b1, h[3], 2'b01};
    endcase
  endfunction

  function automatic instr_t expected_word(input addr_t pc);
    logic [15:0] low;
    low = image_half(pc);
    if (low[1:0] == 2'b11) begin
      return {image_half(pc + 32'd2), low};
    end
    return {16'h0000, low};
  endfunction

  function automatic logic is_jump_word(input instr_t word);
    return (word[6:0] == 7'b1101111) || (word[1:0] == 2'b01 && word[15:13] == 3'b101);
  endfunction

  // Successor PC by the RV32C length and jump rules.
  function automatic addr_t next_pc(input addr_t pc);
    instr_t w;
    addr_t  offset;
    w = expected_word(pc);
    if (w[6:0] == 7'b1101111) begin
      offset = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      return pc + offset;
    end
    if (w[1:0] == 2'b01 && w[15:13] == 3'b101) begin
      offset = {{21{w[12]}}, w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
      return pc + offset;
    end
    return pc + ((w[1:0] == 2'b11) ? 32'd4 : 32'd2);
  endfunction

  function automatic redirect_cause_t winning_cause(input logic t, input logic m, input logic b);
    if (t) return cause_trap;
    if (m) return cause_mret;
    if (b) return cause_branch;
    return cause_none;
  endfunction

  // Memory port and output back-pressure.
  always @(negedge clock) begin
    seed = lcg_next(seed);
    imem_ready = !random_mode || seed[16] || seed[17];
    out_ready = !random_mode || (seed[25:23] < 3'd3); // Low often enough to fill the queue.
    imem_rdata = {image_half(imem_addr + 32'd2), image_half(imem_addr)};
  end

  task automatic check_transfer();
    addr_t  pc;
    instr_t word;
    pc = exp_pc;
    if (target_pending && out_pc === pending_target) begin
      pc = pending_target; // First output of the new path.
      target_pending = 1'b0;
    end
    word = expected_word(pc);
    if (out_pc !== pc) begin
      mismatches++;
      $display("Mismatch at %0t: out_pc %h, expected %h", $time, out_pc, pc);
    end
    if (out_instr !== word) begin
      mismatches++;
      $display("Mismatch at %0t: out_instr %h at pc %h, expected %h", $time, out_instr, pc, word);
    end
    if (out_compressed !== (word[1:0] != 2'b11)) begin
      mismatches++;
      $display("Mismatch at %0t: out_compressed %b at pc %h", $time, out_compressed, pc);
    end
    if (out_jump !== is_jump_word(word)) begin
      mismatches++;
      $display("Mismatch at %0t: out_jump %b at pc %h", $time, out_jump, pc);
    end
    if (phase == 1) begin
      first_stream.push_back(out_pc);
    end else if (phase == 2 && stream_index < first_stream.size()) begin
      if (out_pc !== first_stream[stream_index]) begin
        mismatches++;
        $display("Mismatch at %0t: stalled stream pc %h, free stream had %h", $time, out_pc,
                 first_stream[stream_index]);
      end
      stream_index++;
    end
    transfers++;
    jumps_seen += is_jump_word(word) ? 1 : 0;
    compressed_seen += (word[1:0] != 2'b11) ? 1 : 0;
    exp_pc = next_pc(pc);
  endtask

  // Samples a settled cycle ahead of the next rising edge.
  always begin
    @(negedge clock);
    #1;
    if (!reset && first_req_pending && imem_valid) begin
      first_req_pending = 1'b0;
      if (imem_addr !== `FETCH_RESET_PC) begin
        mismatches++;
        $display("Mismatch at %0t: first imem_addr %h, expected %h", $time, imem_addr,
                 `FETCH_RESET_PC);
      end
    end
    if (!out_valid && out_instr !== `FETCH_NOP) begin
      mismatches++;
      $display("Mismatch at %0t: out_instr %h with out_valid low, expected %h", $time,
               out_instr, `FETCH_NOP);
    end
    if (!reset && out_valid && out_ready) begin
      check_transfer();
    end
  end

  task automatic reset_dut();
    reset = 1'b1;
    repeat (4) begin
      @(negedge clock);
      if (out_valid !== 1'b0) begin
        mismatches++;
        $display("Mismatch at %0t: out_valid %b during reset, expected 0", $time, out_valid);
      end
    end
    reset = 1'b0;
    exp_pc = `FETCH_RESET_PC;
    target_pending = 1'b0;
    first_req_pending = 1'b1;
    @(negedge clock);
    if (out_valid !== 1'b0) begin
      mismatches++;
      $display("Mismatch at %0t: out_valid %b in the first cycle after reset, expected 0",
               $time, out_valid);
    end
  endtask

  task automatic wait_outputs(input int n);
    int goal;
    int cycles;
    goal = transfers + n;
    cycles = 0;
    while (transfers < goal && cycles < n * cycles_per_output) begin
      @(negedge clock);
      cycles++;
    end
    if (transfers < goal) begin
      failures++;
      $display("Output stream stalled with %0d of %0d outputs at %0t", n - (goal - transfers),
               n, $time);
    end
  endtask

  task automatic wait_target();
    int cycles;
    cycles = 0;
    while (target_pending && cycles < 8 * cycles_per_output) begin
      @(negedge clock);
      cycles++;
    end
    if (target_pending) begin
      failures++;
      $display("Redirect target %h never reached the output by %0t", pending_target, $time);
    end
  endtask

  task automatic pulse_redirect(input logic t, input logic m, input logic b);
    redirect_cause_t cause;
    cause = winning_cause(t, m, b);
    trap = t;
    mret = m;
    branch_redirect = b;
    target_pending = 1'b1;
    case (cause)
      cause_trap: pending_target = trap_vector;
      cause_mret: pending_target = return_pc;
      default: pending_target = branch_target;
    endcase
    @(negedge clock);
    trap = 1'b0;
    mret = 1'b0;
    branch_redirect = 1'b0;
    wait_target();
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    imem_ready = 1'b0;
    imem_rdata = `FETCH_NOP;
    out_ready = 1'b0;
    trap = 1'b0;
    trap_vector = 32'h0000_8000;
    mret = 1'b0;
    return_pc = 32'h0000_4A06;
    branch_redirect = 1'b0;
    branch_target = 32'h0000_4000;
    seed = 32'd67;
    random_mode = 1'b0;
    phase = 1;
    stream_index = 0;
    transfers = 0;
    jumps_seen = 0;
    compressed_seen = 0;
    mismatches = 0;
    failures = 0;

    reset_dut();
    wait_outputs(run_outputs); // Ready always high.

    phase = 2;
    random_mode = 1'b1;
    reset_dut();
    wait_outputs(run_outputs);

    phase = 3;
    wait_outputs(3);
    pulse_redirect(1'b0, 1'b0, 1'b1);
    wait_outputs(tail_outputs);

    branch_target = 32'h0000_C000; // Loses to the trap.
    wait_outputs(3);
    pulse_redirect(1'b1, 1'b1, 1'b1);
    wait_outputs(tail_outputs);

    wait_outputs(3);
    pulse_redirect(1'b0, 1'b1, 1'b0);
    wait_outputs(tail_outputs);

    if (jumps_seen == 0) begin
      failures++;
      $display("No jump instruction reached the output");
    end
    if (compressed_seen == 0) begin
      failures++;
      $display("No compressed instruction reached the output");
    end
    $display("Transfers %0d, jumps %0d, mismatches %0d, other errors %0d", transfers,
             jumps_seen, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout after %0d ns, the fetch unit stopped making progress", watchdog_ns);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
  input  logic                    clock,
  input  logic                    reset,
  output logic                    imem_valid,
  output fetch_types_pkg::addr_t  imem_addr,
  input  logic                    imem_ready,
  input  fetch_types_pkg::instr_t imem_rdata,
  input  logic                    trap,
  input  fetch_types_pkg::addr_t  trap_vector,
  input  logic                    mret,
  input  fetch_types_pkg::addr_t  return_pc,
  input  logic                    branch_redirect,
  input  fetch_types_pkg::addr_t  branch_target,
  output logic                    out_valid,
  output fetch_types_pkg::addr_t  out_pc,
  output fetch_types_pkg::instr_t out_instr,
  output logic                    out_compressed,
  output logic                    out_jump,
  input  logic                    out_ready
);

  import fetch_types_pkg::*;

  logic   push_valid;
  addr_t  push_pc;
  instr_t push_instr;
  logic   full;
  logic   head_valid;
  addr_t  head_pc;
  instr_t head_instr;
  logic   pop;
  logic   jump_redirect;
  addr_t  jump_target;
  logic   flush;

  fetch_stage u_fetch_stage (
    .clock           (clock),
    .reset           (reset),
    .trap            (trap),
    .trap_vector     (trap_vector),
    .mret            (mret),
    .return_pc       (return_pc),
    .branch_redirect (branch_redirect),
    .branch_target   (branch_target),
    .jump_redirect   (jump_redirect),
    .jump_target     (jump_target),
    .imem_ready      (imem_ready),
    .imem_rdata      (imem_rdata),
    .imem_valid      (imem_valid),
    .imem_addr       (imem_addr),
    .push_valid      (push_valid),
    .push_pc         (push_pc),
    .push_instr      (push_instr),
    .full            (full),
    .flush           (flush)
  );

  fetch_buffer u_fetch_buffer (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .push_valid (push_valid),
    .push_pc    (push_pc),
    .push_instr (push_instr),
    .full       (full),
    .head_valid (head_valid),
    .head_pc    (head_pc),
    .head_instr (head_instr),
    .pop        (pop)
  );

  instr_predecode u_instr_predecode (
    .clock          (clock),
    .reset          (reset),
    .flush          (flush),
    .head_valid     (head_valid),
    .head_pc        (head_pc),
    .head_instr     (head_instr),
    .pop            (pop),
    .jump_redirect  (jump_redirect),
    .jump_target    (jump_target),
    .out_valid      (out_valid),
    .out_pc         (out_pc),
    .out_instr      (out_instr),
    .out_compressed (out_compressed),
    .out_jump       (out_jump),
    .out_ready      (out_ready)
  );

endmodule

`default_nettype wire

// ==== hw/instr_predecode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module instr_predecode (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    head_valid,
  input  fetch_types_pkg::addr_t  head_pc,
  input  fetch_types_pkg::instr_t head_instr,
  output logic                    pop,
  output logic                    jump_redirect,
  output fetch_types_pkg::addr_t  jump_target,
  output logic                    out_valid,
  output fetch_types_pkg::addr_t  out_pc,
  output fetch_types_pkg::instr_t out_instr,
  output logic                    out_compressed,
  output logic                    out_jump,
  input  logic                    out_ready
);

  import fetch_types_pkg::*;

  logic   is_compressed;
  logic   is_jal;
  logic   is_cj;
  logic   is_jump;
  logic   load;
  addr_t  j_imm;
  addr_t  cj_imm;
  instr_t instr_q;

  assign is_compressed = (head_instr[1:0] != 2'b11);
  assign is_jal = (head_instr[6:0] == 7'b1101111);
  assign is_cj = (head_instr[1:0] == 2'b01) && (head_instr[15:13] == 3'b101);
  assign is_jump = is_jal || is_cj;

  assign j_imm = {{11{head_instr[31]}}, head_instr[31], head_instr[19:12],
                  head_instr[20], head_instr[30:21], 1'b0};

  // Offset bits 11|4|9:8|10|6|7|3:1|5 sit at 12:2.
  assign cj_imm = {{20{head_instr[12]}}, head_instr[12], head_instr[8],
                   head_instr[10:9], head_instr[6], head_instr[7], head_instr[2],
                   head_instr[11], head_instr[5:3], 1'b0};

  assign jump_target = head_pc + (is_cj ? cj_imm : j_imm);

  assign pop = head_valid && (!out_valid || out_ready);
  assign jump_redirect = pop && is_jump;

  // A popped jump survives the flush it causes itself.
  assign load = pop && (is_jump || !flush);

  assign out_instr = out_valid ? instr_q : `FETCH_NOP;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (flush || out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      out_pc <= head_pc;
      instr_q <= is_compressed ? {16'h0000, head_instr[15:0]} : head_instr;
      out_compressed <= is_compressed;
      out_jump <= is_jump;
    end
  end

endmodule

`default_nettype wire

// ==== hw/fetch_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_buffer (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    push_valid,
  input  fetch_types_pkg::addr_t  push_pc,
  input  fetch_types_pkg::instr_t push_instr,
  output logic                    full,
  output logic                    head_valid,
  output fetch_types_pkg::addr_t  head_pc,
  output fetch_types_pkg::instr_t head_instr,
  input  logic                    pop
);

  import fetch_types_pkg::*;

  addr_t    pc_mem [`FETCH_BUF_DEPTH];
  instr_t   instr_mem [`FETCH_BUF_DEPTH];
  buf_ptr_t wr_ptr;
  buf_ptr_t rd_ptr;
  logic     empty;
  logic     write;
  logic     read;

  assign empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[buf_idx_w] != rd_ptr[buf_idx_w]) &&
                (wr_ptr[buf_idx_w-1:0] == rd_ptr[buf_idx_w-1:0]);

  assign write = push_valid && !full;
  assign read = pop && !empty;

  assign head_valid = !empty;
  assign head_pc = pc_mem[rd_ptr[buf_idx_w-1:0]];
  assign head_instr = empty ? `FETCH_NOP : instr_mem[rd_ptr[buf_idx_w-1:0]];

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      wr_ptr <= '0; // Flush also beats a push.
      rd_ptr <= '0;
    end else begin
      if (write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (write && !flush) begin
      pc_mem[wr_ptr[buf_idx_w-1:0]] <= push_pc;
      instr_mem[wr_ptr[buf_idx_w-1:0]] <= push_instr;
    end
  end

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   trap,
  input  fetch_types_pkg::addr_t trap_vector,
  input  logic                   mret,
  input  fetch_types_pkg::addr_t return_pc,
  input  logic                   branch_redirect,
  input  fetch_types_pkg::addr_t branch_target,
  input  logic                   jump_redirect,
  input  fetch_types_pkg::addr_t jump_target,
  input  logic                   imem_ready,
  input  fetch_types_pkg::instr_t imem_rdata,
  output logic                   imem_valid,
  output fetch_types_pkg::addr_t imem_addr,
  output logic                   push_valid,
  output fetch_types_pkg::addr_t push_pc,
  output fetch_types_pkg::instr_t push_instr,
  input  logic                   full,
  output logic                   flush
);

  import fetch_types_pkg::*;
  import fetch_ctrl_pkg::*;

  fetch_state_t    state;
  redirect_cause_t cause;
  addr_t           pc;
  addr_t           redirect_pc;
  addr_t           seq_pc;
  logic            accept;
  logic            entry_valid;
  addr_t           entry_pc;
  instr_t          entry_instr;

  always_comb begin
    cause = cause_none;
    redirect_pc = pc;
    if (trap) begin
      cause = cause_trap;
      redirect_pc = trap_vector;
    end else if (mret) begin
      cause = cause_mret;
      redirect_pc = return_pc;
    end else if (branch_redirect) begin
      cause = cause_branch;
      redirect_pc = branch_target;
    end else if (jump_redirect) begin
      cause = cause_jump;
      redirect_pc = jump_target;
    end
  end

  assign flush = (cause != cause_none);

  assign imem_valid = (state == fetch_request);
  assign imem_addr = pc;
  assign accept = imem_valid && imem_ready;

  // Step by the length of the word just returned.
  assign seq_pc = pc + ((imem_rdata[1:0] == 2'b11) ? 32'd4 : 32'd2);

  assign push_valid = entry_valid;
  assign push_pc = entry_pc;
  assign push_instr = entry_valid ? entry_instr : `FETCH_NOP;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= fetch_idle;
      pc <= `FETCH_RESET_PC;
      entry_valid <= 1'b0;
    end else if (flush) begin
      state <= fetch_request; // Pending request is dropped.
      pc <= redirect_pc;
      entry_valid <= 1'b0;
    end else begin
      case (state)
        fetch_idle, fetch_hold: begin
          if (!entry_valid || !full) begin
            state <= fetch_request; // Entry enters the queue now.
            entry_valid <= 1'b0;
          end else begin
            state <= fetch_hold;
          end
        end
        fetch_request: begin
          if (accept) begin
            state <= fetch_idle; // One cycle gap for the push.
            pc <= seq_pc;
            entry_valid <= 1'b1;
          end
        end
        default: begin
          state <= fetch_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept && !flush) begin
      entry_pc <= pc;
      entry_instr <= imem_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== hw/fetch_ctrl_pkg.sv ====
`default_nettype none

package fetch_ctrl_pkg;

  // Highest priority first, after cause_none.
  typedef enum logic [2:0] {
    cause_none   = 3'd0,
    cause_trap   = 3'd1,
    cause_mret   = 3'd2,
    cause_branch = 3'd3,
    cause_jump   = 3'd4
  } redirect_cause_t;

  typedef enum logic [1:0] {
    fetch_idle    = 2'd0, // No request, entry may be pending.
    fetch_request = 2'd1, // Request on the memory port.
    fetch_hold    = 2'd2  // Entry blocked by a full queue.
  } fetch_state_t;

endpackage

`default_nettype wire

// ==== hw/fetch_types_pkg.sv ====
`default_nettype none

`include "fetch_macros.svh"

package fetch_types_pkg;

  localparam int buf_idx_w = $clog2(`FETCH_BUF_DEPTH); // Index bits of the queue.

  typedef logic [31:0] addr_t;

  // Compressed forms use only the low half.
  typedef logic [31:0] instr_t;

  typedef logic [buf_idx_w:0] buf_ptr_t; // Top bit flips on wrap.

endpackage

`default_nettype wire

// ==== include/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// First fetch address out of reset.
`define FETCH_RESET_PC 32'h0000_0100

// Entries in the fetch queue, a power of two.
`define FETCH_BUF_DEPTH 4

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

`endif
